/* project.f */
logic/uart_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_rx_fifo.sv
logic/uart_top.sv
sim/uart_chk.sv
sim/uart_tb.sv

/* Bender.yml */
package:
  name: uart

sources:
  - logic/uart_pkg.sv
  - logic/uart_rx.sv
  - logic/uart_tx.sv
  - logic/uart_rx_fifo.sv
  - logic/uart_top.sv
  - target: simulation
    files:
      - sim/uart_chk.sv
      - sim/uart_tb.sv

/* sim/uart_tb.sv */
// UART subsystem testbench
// directed tests over loopback and a direct serial driver, with every
// received word checked against a queue of expected words

module uart_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW        = 8;
    localparam int DIV       = 8;
    localparam int FRAMES    = 33;              // frames sent over all tests
    localparam int FRAME_MAX = DIV * (DW + 3);  // frame with parity
    localparam int LIMIT     = 2 * FRAMES * FRAME_MAX;

    logic          clk;
    logic          rstn;
    logic [15:0]   clk_divider;
    logic          parity_odd;
    logic          parity_even;
    logic [DW-1:0] s_tdata;
    logic          s_tvalid;
    logic          s_tready;
    logic [DW-1:0] m_tdata;
    logic          m_tvalid;
    logic          m_tready;
    logic          uart_tx;
    logic          uart_rx;
    logic          parity_err;
    logic          overrun;
    logic          loopback;
    logic          drv_line;

    logic [DW-1:0] exp_q[$];  // words expected on m_tdata_o, in order
    int            errors;
    int            checks;
    int            tests;
    int            overruns;
    int            cycles;
    logic          perr_seen;
    integer        seed;

    uart_top #(
        .DATA_WIDTH(DW),
        .FIFO_DEPTH(4)
    ) dut (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .clk_divider_i(clk_divider),
        .parity_odd_i (parity_odd),
        .parity_even_i(parity_even),
        .s_tdata_i    (s_tdata),
        .s_tvalid_i   (s_tvalid),
        .s_tready_o   (s_tready),
        .m_tdata_o    (m_tdata),
        .m_tvalid_o   (m_tvalid),
        .m_tready_i   (m_tready),
        .uart_rx_i    (uart_rx),
        .uart_tx_o    (uart_tx),
        .parity_err_o (parity_err),
        .overrun_o    (overrun)
    );

    assign uart_rx = loopback ? uart_tx : drv_line;  // line mux

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%-22s ok", name);
        end else begin
            $display("%-22s %0d errors", name, errors - err_before);
        end
    endtask

    // receive stream monitor, values as seen by the DUT at the edge
    always @(posedge clk) begin
        if (rstn) begin
            if (overrun) overruns++;
            if (parity_err) perr_seen = 1'b1;
            if (m_tvalid && m_tready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("at %0t an unexpected word 0x%0h left the receive stream",
                             $time, m_tdata);
                end else begin
                    compare("m_tdata_o", m_tdata, exp_q.pop_front());
                end
            end
        end
    end

    // even is xor of data, odd its inverse
    function automatic logic frame_parity(input logic [DW-1:0] d);
        return parity_odd ? ~(^d) : ^d;
    endfunction

    task automatic drive_bit(input logic b);
        drv_line <= b;
        repeat (DIV) @(posedge clk);
    endtask

    task automatic drive_frame(input logic [DW-1:0] d, input logic bad_parity);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < DW; i++) begin
            drive_bit(d[i]);  // lsb first
        end
        if (parity_odd || parity_even) begin
            drive_bit(frame_parity(d) ^ bad_parity);
        end
        drive_bit(1'b1);
    endtask

    // busy returns the cycles s_tready_o stayed low after the transfer
    task automatic stream_word(input logic [DW-1:0] d, output int busy);
        s_tdata  <= d;
        s_tvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_tready);
        s_tvalid <= 1'b0;
        busy = 0;
        @(posedge clk);
        while (!s_tready) begin
            busy++;
            @(posedge clk);
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
        compare("m_tvalid_o", m_tvalid, 1'b0);  // nothing left behind
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_test();
        int e0;
        e0 = errors;
        compare("s_tready_o", s_tready, 1'b1);
        compare("m_tvalid_o", m_tvalid, 1'b0);
        compare("parity_err_o", parity_err, 1'b0);
        compare("overrun_o", overrun, 1'b0);
        compare("uart_tx_o", uart_tx, 1'b1);
        report("reset_values", e0);
    endtask

    task automatic loopback_test(input string name, input logic odd, input logic even);
        int            e0;
        int            busy;
        int            k;
        logic [DW-1:0] w;
        e0 = errors;
        parity_odd  <= odd;
        parity_even <= even;
        loopback    <= 1'b1;
        m_tready    <= 1'b1;
        @(posedge clk);
        perr_seen = 1'b0;
        for (k = 0; k < 8; k++) begin
            w = DW'($random(seed));
            exp_q.push_back(w);
            stream_word(w, busy);
            compare("s_tready_o low cycles", busy, DIV * (DW + 2 + int'(odd | even)));
        end
        drain();
        compare("parity_err_o seen", perr_seen, 1'b0);
        report(name, e0);
    endtask

    task automatic parity_error_test();
        int            e0;
        logic [DW-1:0] w;
        e0 = errors;
        parity_odd  <= 1'b0;
        parity_even <= 1'b1;
        loopback    <= 1'b0;
        drv_line    <= 1'b1;
        @(posedge clk);
        repeat (2) begin
            w = DW'($random(seed));
            drive_frame(w, 1'b1);  // no word may appear
            compare("parity_err_o", parity_err, 1'b1);
        end
        w = DW'($random(seed));
        exp_q.push_back(w);
        drive_frame(w, 1'b0);
        drain();
        compare("parity_err_o", parity_err, 1'b0);
        report("parity_error", e0);
    endtask

    task automatic false_start_test();
        int            e0;
        logic [DW-1:0] w;
        e0 = errors;
        parity_odd  <= 1'b0;
        parity_even <= 1'b0;
        loopback    <= 1'b0;
        @(posedge clk);
        drv_line <= 1'b0;  // one cycle, under a quarter bit
        @(posedge clk);
        drive_bit(1'b1);
        w = DW'($random(seed));
        exp_q.push_back(w);
        drive_frame(w, 1'b0);
        drain();
        report("false_start", e0);
    endtask

    task automatic overrun_test();
        int            e0;
        int            busy;
        int            k;
        logic [DW-1:0] w;
        e0 = errors;
        loopback <= 1'b1;
        m_tready <= 1'b0;
        @(posedge clk);
        overruns = 0;
        for (k = 0; k < 5; k++) begin
            w = DW'($random(seed));
            if (k < 4) exp_q.push_back(w);  // fifth finds the FIFO full
            stream_word(w, busy);
        end
        while (overruns == 0) @(posedge clk);
        m_tready <= 1'b1;
        drain();
        compare("overrun_o pulses", overruns, 1);
        report("backpressure_overrun", e0);
    endtask

    initial begin
        seed      = 32'hc1f0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        overruns  = 0;
        perr_seen = 1'b0;
        rstn        <= 1'b0;
        clk_divider <= 16'(DIV);
        parity_odd  <= 1'b0;
        parity_even <= 1'b0;
        s_tdata     <= '0;
        s_tvalid    <= 1'b0;
        m_tready    <= 1'b1;
        loopback    <= 1'b0;
        drv_line    <= 1'b1;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        reset_test();
        loopback_test("loopback_no_parity", 1'b0, 1'b0);
        loopback_test("loopback_odd_parity", 1'b1, 1'b0);
        loopback_test("loopback_even_parity", 1'b0, 1'b1);
        parity_error_test();
        false_start_test();
        overrun_test();
        if (dut.u_chk.fails != 0) begin
            $display("%0d assertion failures in the bound checker", dut.u_chk.fails);
            errors += dut.u_chk.fails;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sim/uart_chk.sv */
// UART subsystem checker
// receive stream stability, idle line level and parity error
// exclusivity, bound into the top level

module uart_chk #(
    parameter int DATA_WIDTH = 8
) (
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  s_tready_i,
    input logic                  tx_i,
    input logic [DATA_WIDTH-1:0] m_tdata_i,
    input logic                  m_tvalid_i,
    input logic                  m_tready_i,
    input logic                  parity_err_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;

    // held word stays until taken
    a_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_tdata_i))
    else begin
        fails++;
        $error("receive stream word changed or dropped before its transfer");
    end

    a_idle_line: assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_tready_i |-> tx_i)
    else begin
        fails++;
        $error("serial line low while the transmitter is idle");
    end

    // error stands until the next start bit, so a bad frame's word would rise under it
    a_err_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(m_tvalid_i) |-> !parity_err_i)
    else begin
        fails++;
        $error("received word appeared while a parity error was flagged");
    end

endmodule

bind uart_top uart_chk #(
    .DATA_WIDTH(DATA_WIDTH)
) u_chk (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .s_tready_i  (s_tready_o),
    .tx_i        (uart_tx_o),
    .m_tdata_i   (m_tdata_o),
    .m_tvalid_i  (m_tvalid_o),
    .m_tready_i  (m_tready_i),
    .parity_err_i(parity_err_o)
);

/* logic/uart_top.sv */
// UART subsystem top
// transmitter on the input stream, receiver and receive FIFO on the
// output stream, sharing one bit period and parity mode

module uart_top
    import uart_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  divider_t              clk_divider_i,
    input  logic                  parity_odd_i,
    input  logic                  parity_even_i,
    // transmit stream
    input  logic [DATA_WIDTH-1:0] s_tdata_i,
    input  logic                  s_tvalid_i,
    output logic                  s_tready_o,
    // receive stream
    output logic [DATA_WIDTH-1:0] m_tdata_o,
    output logic                  m_tvalid_o,
    input  logic                  m_tready_i,
    // serial line and status
    input  logic                  uart_rx_i,
    output logic                  uart_tx_o,
    output logic                  parity_err_o,
    output logic                  overrun_o
);

    logic [DATA_WIDTH-1:0] rx_word;
    logic                  rx_word_valid;

    uart_tx #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_tx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .clk_divider_i(clk_divider_i),
        .parity_odd_i (parity_odd_i),
        .parity_even_i(parity_even_i),
        .s_tdata_i    (s_tdata_i),
        .s_tvalid_i   (s_tvalid_i),
        .s_tready_o   (s_tready_o),
        .uart_tx_o    (uart_tx_o)
    );

    uart_rx #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_rx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .clk_divider_i(clk_divider_i),
        .parity_odd_i (parity_odd_i),
        .parity_even_i(parity_even_i),
        .uart_rx_i    (uart_rx_i),
        .word_o       (rx_word),
        .word_valid_o (rx_word_valid),
        .parity_err_o (parity_err_o)
    );

    // no back-pressure toward the receiver
    uart_rx_fifo #(
        .DATA_WIDTH(DATA_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .word_i      (rx_word),
        .word_valid_i(rx_word_valid),
        .m_tdata_o   (m_tdata_o),
        .m_tvalid_o  (m_tvalid_o),
        .m_tready_i  (m_tready_i),
        .overrun_o   (overrun_o)
    );

endmodule

/* logic/uart_rx_fifo.sv */
// UART receive FIFO
// buffers received words for the output stream; a word that arrives
// while full with no read is dropped and flagged by an overrun pulse

module uart_rx_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [DATA_WIDTH-1:0] word_i,
    input  logic                  word_valid_i,
    output logic [DATA_WIDTH-1:0] m_tdata_o,
    output logic                  m_tvalid_o,
    input  logic                  m_tready_i,
    output logic                  overrun_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic                  full;
    logic                  do_read;
    logic                  do_write;

    assign full     = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign do_read  = m_tvalid_o & m_tready_i;
    assign do_write = word_valid_i & (~full | do_read);  // full plus read still fits

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr] <= word_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overrun_o <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overrun_o <= word_valid_i & ~do_write;
        end
    end

    assign m_tvalid_o = (count != '0);
    assign m_tdata_o  = mem[rd_ptr];

endmodule

/* logic/uart_tx.sv */
// UART transmitter
// accepts one word per frame from the input stream and shifts out
// start bit, data LSB first, optional parity and one stop bit

module uart_tx
    import uart_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  divider_t              clk_divider_i,
    input  logic                  parity_odd_i,
    input  logic                  parity_even_i,
    input  logic [DATA_WIDTH-1:0] s_tdata_i,
    input  logic                  s_tvalid_i,
    output logic                  s_tready_o,
    output logic                  uart_tx_o
);

    localparam int CNT_W = $clog2(DATA_WIDTH);

    tx_state_e             state;
    divider_t              baud_cnt;
    logic                  baud_done;
    logic [CNT_W-1:0]      bit_idx;
    logic                  bit_last;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  tx_parity;
    logic                  s_handshake;

    assign s_tready_o  = (state == TX_IDLE);
    assign s_handshake = s_tvalid_i & s_tready_o;
    assign baud_done   = (baud_cnt == clk_divider_i - divider_t'(1));
    assign bit_last    = (bit_idx == CNT_W'(DATA_WIDTH - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word and parity latch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (s_handshake) begin
            tx_data   <= s_tdata_i;
            tx_parity <= parity(16'(s_tdata_i), parity_odd_i, parity_even_i);
        end
    end

    // one bit period per state step
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            baud_cnt <= '0;
        end else if (state == TX_IDLE || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + divider_t'(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit FSM, line driven from a flop
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state     <= TX_IDLE;
            bit_idx   <= '0;
            uart_tx_o <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_idx <= '0;
                    if (s_handshake) begin
                        state     <= TX_START;
                        uart_tx_o <= 1'b0;  // start bit from next cycle
                    end
                end
                TX_START: begin
                    if (baud_done) begin
                        state     <= TX_DATA;
                        uart_tx_o <= tx_data[0];
                    end
                end
                TX_DATA: begin
                    if (baud_done) begin
                        if (!bit_last) begin
                            bit_idx   <= bit_idx + 1'b1;
                            uart_tx_o <= tx_data[bit_idx + 1'b1];
                        end else if (parity_odd_i | parity_even_i) begin
                            state     <= TX_PARITY;
                            uart_tx_o <= tx_parity;
                        end else begin
                            state     <= TX_STOP;
                            uart_tx_o <= 1'b1;
                        end
                    end
                end
                TX_PARITY: begin
                    if (baud_done) begin
                        state     <= TX_STOP;
                        uart_tx_o <= 1'b1;
                    end
                end
                TX_STOP: begin
                    if (baud_done) begin
                        state <= TX_IDLE;  // ready again next cycle
                    end
                end
                default: begin
                    state     <= TX_IDLE;
                    uart_tx_o <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* logic/uart_rx.sv */
// UART receiver
// synchronizes the serial line, rejects short start pulses, samples
// each bit in its middle and checks parity; good words leave as a
// one-cycle strobe

module uart_rx
    import uart_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  divider_t              clk_divider_i,
    input  logic                  parity_odd_i,
    input  logic                  parity_even_i,
    input  logic                  uart_rx_i,
    output logic [DATA_WIDTH-1:0] word_o,
    output logic                  word_valid_o,
    output logic                  parity_err_o
);

    localparam int CNT_W = $clog2(DATA_WIDTH);

    rx_state_e             state;
    logic [1:0]            rx_sync;
    logic                  rx_line;
    divider_t              baud_cnt;
    divider_t              half_m1;
    divider_t              full_m1;
    logic                  baud_done;
    logic                  start_check;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  bit_last;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  parity_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_sync <= 2'b11;  // idle line is high
        end else begin
            rx_sync <= {rx_sync[0], uart_rx_i};
        end
    end

    assign rx_line = rx_sync[1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit period counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign half_m1     = (clk_divider_i >> 1) - divider_t'(1);
    assign full_m1     = clk_divider_i - divider_t'(1);
    assign start_check = (state == RX_START) && (baud_cnt == half_m1);
    assign baud_done   = (state != RX_START) && (baud_cnt == full_m1);
    assign bit_last    = (bit_cnt == CNT_W'(DATA_WIDTH - 1));
    assign parity_en   = parity_odd_i | parity_even_i;

    // restarts at the half-bit check, so later ticks land mid-bit
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            baud_cnt <= '0;
        end else if (state == RX_IDLE || start_check || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + divider_t'(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state        <= RX_IDLE;
            bit_cnt      <= '0;
            parity_err_o <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_line) begin
                        state        <= RX_START;
                        parity_err_o <= 1'b0;  // new frame clears old error
                    end
                end
                RX_START: begin
                    if (start_check) begin
                        state <= rx_line ? RX_IDLE : RX_DATA;  // high here is a glitch
                    end
                end
                RX_DATA: begin
                    if (baud_done) begin
                        if (bit_last) begin
                            state <= parity_en ? RX_PARITY : RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_PARITY: begin
                    if (baud_done) begin
                        state        <= RX_STOP;
                        parity_err_o <= (rx_line != parity(16'(rx_data), parity_odd_i,
                                                           parity_even_i));
                    end
                end
                RX_STOP: begin
                    if (baud_done) begin
                        state <= RX_DONE;  // stop level is not checked
                    end
                end
                RX_DONE: begin
                    state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data bits, LSB first
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && baud_done) begin
            rx_data[bit_cnt] <= rx_line;
        end
    end

    assign word_o       = rx_data;
    assign word_valid_o = (state == RX_DONE) && !parity_err_o;

endmodule

/* logic/uart_pkg.sv */
// UART shared definitions
// bit period type, receiver and transmitter FSM states, and the
// parity rule used by both directions of the link

package uart_pkg;

    // clock cycles per serial bit, minimum 4
    typedef logic [15:0] divider_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        RX_IDLE   = 3'b000,
        RX_START  = 3'b001,
        RX_DATA   = 3'b010,
        RX_PARITY = 3'b011,
        RX_STOP   = 3'b100,
        RX_DONE   = 3'b101
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE   = 3'b000,
        TX_START  = 3'b001,
        TX_DATA   = 3'b010,
        TX_PARITY = 3'b011,
        TX_STOP   = 3'b100
    } tx_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // parity
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // odd wins over even; unused upper data bits must be zero
    function automatic logic parity(
        input logic [15:0] data,
        input logic        odd,
        input logic        even
    );
        logic x;
        x = ^data;
        if (odd) begin
            return ~x;
        end else if (even) begin
            return x;
        end
        return 1'b0;  // no parity
    endfunction

endpackage
